/* logic/isa_pkg.sv */
// MIPS integer ISA encodings
// register index, opcode and funct values, and the two views of an instruction word
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_addr_t;  // $0 never causes a hazard
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    typedef struct packed {
        opcode_t    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // destination is rd in the R view, rt in the I view
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    localparam reg_addr_t REG_RA = 5'd31;  // jal link register

    localparam opcode_t OP_SPECIAL  = 6'h00;
    localparam opcode_t OP_SPECIAL2 = 6'h1c;
    localparam opcode_t OP_J        = 6'h02;
    localparam opcode_t OP_JAL      = 6'h03;
    localparam opcode_t OP_BEQ      = 6'h04;
    localparam opcode_t OP_BNE      = 6'h05;
    localparam opcode_t OP_BLEZ     = 6'h06;
    localparam opcode_t OP_BGTZ     = 6'h07;
    localparam opcode_t OP_ADDIU    = 6'h09;
    localparam opcode_t OP_SLTI     = 6'h0a;
    localparam opcode_t OP_ANDI     = 6'h0c;
    localparam opcode_t OP_ORI      = 6'h0d;
    localparam opcode_t OP_LUI      = 6'h0f;
    localparam opcode_t OP_LW       = 6'h23;
    localparam opcode_t OP_SW       = 6'h2b;

    // SPECIAL functs
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_SLLV  = 6'h04;
    localparam funct_t FN_JR    = 6'h08;
    localparam funct_t FN_JALR  = 6'h09;
    localparam funct_t FN_MFHI  = 6'h10;
    localparam funct_t FN_MTHI  = 6'h11;
    localparam funct_t FN_MFLO  = 6'h12;
    localparam funct_t FN_MTLO  = 6'h13;
    localparam funct_t FN_MULT  = 6'h18;
    localparam funct_t FN_MULTU = 6'h19;
    localparam funct_t FN_DIV   = 6'h1a;
    localparam funct_t FN_DIVU  = 6'h1b;
    localparam funct_t FN_ADDU  = 6'h21;
    localparam funct_t FN_SUBU  = 6'h23;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_OR    = 6'h25;
    localparam funct_t FN_SLT   = 6'h2a;
    localparam funct_t FN_CLZ   = 6'h20;  // SPECIAL2
    localparam funct_t FN_CLO   = 6'h21;  // SPECIAL2

endpackage

`default_nettype wire

/* logic/hazard_pkg.sv */
// stall bookkeeping types
// function groups, Tuse/Tnew timing values and per-stage producer info
`default_nettype none

package hazard_pkg;

    typedef enum logic [2:0] {
        NOP       = 3'd0,  // bubble, all-zero word
        CALC_R    = 3'd1,
        CALC_I    = 3'd2,
        MEM_READ  = 3'd3,
        MEM_WRITE = 3'd4,
        BRANCH    = 3'd5,
        JUMP      = 3'd6,
        MULTDIV   = 3'd7
    } func_e;

    typedef logic [1:0] t_val_t;  // cycles, 0 to 3

    // operand not read; tnew never exceeds it
    localparam t_val_t TUSE_INF = 2'd3;

    typedef struct packed {
        isa_pkg::reg_addr_t dest;      // 0 when nothing is written
        t_val_t             tnew;      // cycles until result is ready
        logic               md_start;  // mult/div launches from this stage
    } stage_info_t;

endpackage

`default_nettype wire

/* logic/instr_class.sv */
// instruction classifier
// maps an instruction word to its function group
// unknown encodings act as bubbles
`timescale 1ns/1ns
`default_nettype none

module instr_class (
    input  isa_pkg::instr_u   instr,
    output hazard_pkg::func_e func
);
    import isa_pkg::*;
    import hazard_pkg::*;

    always_comb begin
        func = NOP;
        if (instr != '0) begin
            case (instr.r_fmt.op)
                OP_SPECIAL: begin
                    case (instr.r_fmt.funct)
                        FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
                        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT: func = CALC_R;
                        FN_JR, FN_JALR:                          func = JUMP;
                        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
                        FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO:      func = MULTDIV;
                        default:                                 func = NOP;
                    endcase
                end
                OP_SPECIAL2: begin
                    if (instr.r_fmt.funct == FN_CLO || instr.r_fmt.funct == FN_CLZ) begin
                        func = CALC_R;  // counts behave like plain ALU ops
                    end
                end
                OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: func = CALC_I;
                OP_LW:                                      func = MEM_READ;
                OP_SW:                                      func = MEM_WRITE;
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:           func = BRANCH;
                OP_J, OP_JAL:                               func = JUMP;
                default:                                    func = NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/tuse_tnew_decode.sv */
// Tuse/Tnew decoder for the ID stage
// gives operand use times, result time, destination and the mult/div launch flag
`timescale 1ns/1ns
`default_nettype none

module tuse_tnew_decode (
    input  isa_pkg::instr_u         instr,
    output hazard_pkg::func_e       func,
    output hazard_pkg::t_val_t      tuse_rs,
    output hazard_pkg::t_val_t      tuse_rt,
    output hazard_pkg::stage_info_t id_info
);
    import isa_pkg::*;
    import hazard_pkg::*;

    opcode_t   op;
    funct_t    funct;
    logic      is_special;
    logic      is_shift_imm;  // sll/srl/sra ignore rs
    logic      is_md_op;      // mult/multu/div/divu
    logic      is_mt;
    logic      is_mf;
    logic      is_link;       // jal/jalr
    t_val_t    tnew_raw;
    reg_addr_t dest_raw;

    instr_class u_class (
        .instr (instr),
        .func  (func)
    );

    assign op           = instr.r_fmt.op;
    assign funct        = instr.r_fmt.funct;
    assign is_special   = (op == OP_SPECIAL);
    assign is_shift_imm = is_special && (funct inside {FN_SLL, FN_SRL, FN_SRA});
    assign is_md_op     = is_special && (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
    assign is_mt        = is_special && (funct inside {FN_MTHI, FN_MTLO});
    assign is_mf        = is_special && (funct inside {FN_MFHI, FN_MFLO});
    assign is_link      = (op == OP_JAL) || (is_special && funct == FN_JALR);

    always_comb begin
        tuse_rs  = TUSE_INF;
        tuse_rt  = TUSE_INF;
        tnew_raw = '0;
        case (func)
            CALC_R: begin
                tuse_rs  = is_shift_imm ? TUSE_INF : 2'd1;
                tuse_rt  = (op == OP_SPECIAL2) ? TUSE_INF : 2'd1;  // clo/clz read rs only
                tnew_raw = 2'd2;
            end
            CALC_I: begin
                tuse_rs  = (op == OP_LUI) ? TUSE_INF : 2'd1;
                tnew_raw = (op == OP_LUI) ? 2'd1 : 2'd2;
            end
            MEM_READ: begin
                tuse_rs  = 2'd1;  // address calc in EX
                tnew_raw = 2'd3;
            end
            MEM_WRITE: begin
                tuse_rs = 2'd1;
                tuse_rt = 2'd2;  // store data needed in MEM
            end
            BRANCH: begin
                tuse_rs = 2'd0;  // compared in ID
                tuse_rt = (op == OP_BEQ || op == OP_BNE) ? 2'd0 : TUSE_INF;
            end
            JUMP: begin
                tuse_rs  = is_special ? 2'd0 : TUSE_INF;  // jr/jalr target
                tnew_raw = is_link ? 2'd1 : 2'd0;
            end
            MULTDIV: begin
                tuse_rs  = (is_md_op || is_mt) ? 2'd1 : TUSE_INF;
                tuse_rt  = is_md_op ? 2'd1 : TUSE_INF;
                tnew_raw = is_mf ? 2'd2 : 2'd0;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (tnew_raw == '0) begin
            dest_raw = '0;
        end else if (op == OP_JAL) begin
            dest_raw = REG_RA;
        end else if (is_special || op == OP_SPECIAL2) begin
            dest_raw = instr.r_fmt.rd;
        end else begin
            dest_raw = instr.i_fmt.rt;  // I-type writes rt
        end
        id_info.dest     = dest_raw;
        id_info.tnew     = (dest_raw == '0) ? 2'd0 : tnew_raw;  // writes to $0 vanish
        id_info.md_start = (func == MULTDIV) && is_md_op;
    end

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
// hazard unit
// checks ID operands against EX/MEM producers and the mult/div unit
// and raises the stall controls
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  isa_pkg::instr_u         instr_id,
    input  hazard_pkg::stage_info_t ex_info,
    input  hazard_pkg::stage_info_t mem_info,
    input  logic                    md_busy,
    output hazard_pkg::stage_info_t id_info,
    output logic                    stall_pc,
    output logic                    stall_id,
    output logic                    clr_ex
);
    import isa_pkg::*;
    import hazard_pkg::*;

    func_e  func_id;
    t_val_t tuse_rs;
    t_val_t tuse_rt;
    logic   stall_rs;
    logic   stall_rt;
    logic   stall_md;
    logic   stall;

    tuse_tnew_decode u_decode (
        .instr   (instr_id),
        .func    (func_id),
        .tuse_rs (tuse_rs),
        .tuse_rt (tuse_rt),
        .id_info (id_info)
    );

    // producer writes src but its result comes too late for this use
    function automatic logic too_late(reg_addr_t src, t_val_t tuse, stage_info_t prod);
        return (prod.dest == src) && (prod.tnew > tuse);
    endfunction

    assign stall_rs = (instr_id.r_fmt.rs != '0) &&
                      (too_late(instr_id.r_fmt.rs, tuse_rs, ex_info) ||
                       too_late(instr_id.r_fmt.rs, tuse_rs, mem_info));
    assign stall_rt = (instr_id.r_fmt.rt != '0) &&
                      (too_late(instr_id.r_fmt.rt, tuse_rt, ex_info) ||
                       too_late(instr_id.r_fmt.rt, tuse_rt, mem_info));
    assign stall_md = md_busy && (func_id == MULTDIV);  // hi/lo still in flight

    assign stall    = stall_rs || stall_rt || stall_md;
    assign stall_pc = stall;  // hold fetch
    assign stall_id = stall;  // hold decode
    assign clr_ex   = stall;  // bubble into EX

endmodule

`default_nettype wire

/* logic/stage_tracker.sv */
// EX/MEM producer tracker
// carries dest and Tnew down the pipe
// Tnew counts down once per stage
`timescale 1ns/1ns
`default_nettype none

module stage_tracker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  hazard_pkg::stage_info_t id_info,
    input  logic                    clr_ex,
    output hazard_pkg::stage_info_t ex_info,
    output hazard_pkg::stage_info_t mem_info
);
    import hazard_pkg::*;

    // one stage closer to the result with a floor at 0
    function automatic stage_info_t advance(stage_info_t cur);
        stage_info_t nxt;
        nxt = cur;
        if (cur.tnew != '0) begin
            nxt.tnew = cur.tnew - 2'd1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_info  <= '0;
            mem_info <= '0;
        end else begin
            ex_info  <= clr_ex ? stage_info_t'('0) : advance(id_info);  // bubble on stall
            mem_info <= advance(ex_info);
        end
    end

    // $0 is never a producer, so no result time may ride on it
    assert property (@(posedge clk) disable iff (!arst_n)
        (ex_info.dest == '0) |-> (ex_info.tnew == '0))
        else $error("stage_tracker: EX carries tnew with dest 0");

    assert property (@(posedge clk) disable iff (!arst_n)
        (mem_info.dest == '0) |-> (mem_info.tnew == '0))
        else $error("stage_tracker: MEM carries tnew with dest 0");

endmodule

`default_nettype wire

/* logic/md_busy_timer.sv */
// multiply/divide busy timer
// busy while the op sits in EX, then for MD_CYCLES more cycles
`timescale 1ns/1ns
`default_nettype none

module md_busy_timer #(
    parameter int unsigned MD_CYCLES = 5
) (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic md_busy
);
    localparam int unsigned CNT_W = $clog2(MD_CYCLES + 1);

    logic [CNT_W-1:0] count;  // cycles left in the unit

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(MD_CYCLES);
        end else if (count != '0) begin
            count <= count - CNT_W'(1);
        end
    end

    assign md_busy = start || (count != '0);

endmodule

`default_nettype wire

/* logic/hazard_ctrl_top.sv */
// stall control top level
// decoder and hazard unit in ID, producer tracker for EX/MEM, mult/div busy timer
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl_top #(
    parameter int unsigned MD_CYCLES = 5
) (
    input  logic            clk,
    input  logic            arst_n,
    input  isa_pkg::instr_u instr_id,  // held by the pipeline while stall_id
    output logic            stall_pc,
    output logic            stall_id,
    output logic            clr_ex
);
    import hazard_pkg::*;

    stage_info_t id_info;
    stage_info_t ex_info;
    stage_info_t mem_info;
    logic        md_busy;

    hazard_unit u_hazard (
        .instr_id (instr_id),
        .ex_info  (ex_info),
        .mem_info (mem_info),
        .md_busy  (md_busy),
        .id_info  (id_info),
        .stall_pc (stall_pc),
        .stall_id (stall_id),
        .clr_ex   (clr_ex)
    );

    stage_tracker u_tracker (
        .clk      (clk),
        .arst_n   (arst_n),
        .id_info  (id_info),
        .clr_ex   (clr_ex),
        .ex_info  (ex_info),
        .mem_info (mem_info)
    );

    md_busy_timer #(
        .MD_CYCLES (MD_CYCLES)
    ) u_md_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (ex_info.md_start),
        .md_busy (md_busy)
    );

endmodule

`default_nettype wire

/* dv/hazard_tb.sv */
// testbench for the stall-control block
// runs producer/gap/consumer rows and counts the stall cycles of each consumer
`timescale 1ns/1ns
`default_nettype none

module hazard_tb;
    import isa_pkg::*;

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 5;
    localparam int MD_CYCLES    = 5;  // dut default
    localparam int DRAIN        = MD_CYCLES + 2;  // EX, MEM and the mult/div count
    localparam int MARGIN       = 20;

    typedef struct packed {
        logic [31:0] prod;
        int          gap;         // NOPs between producer and consumer
        logic [31:0] cons;
        int          exp_stalls;
    } row_t;

    logic    clk;
    logic    arst_n;
    instr_u  instr_id;
    logic    stall_pc;
    logic    stall_id;
    logic    clr_ex;

    row_t      rows[$];
    string     labels[$];
    integer    seed = 62;
    int        error_count = 0;
    int        pass_count = 0;
    int        cycle_count = 0;
    int        cycle_limit = 1000;  // replaced once the table is built
    reg_addr_t d;
    reg_addr_t s;
    reg_addr_t x;
    reg_addr_t y;

    hazard_ctrl_top dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .instr_id (instr_id),
        .stall_pc (stall_pc),
        .stall_id (stall_id),
        .clr_ex   (clr_ex)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic [31:0] r_word(funct_t fn, reg_addr_t rs, reg_addr_t rt,
                                           reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // picks from 1 to 30 to keep clear of $0 and the jal link register
    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(1 + ($unsigned($random(seed)) % 30));
    endfunction

    function automatic reg_addr_t rand_reg_except(reg_addr_t a, reg_addr_t b);
        reg_addr_t r;
        r = rand_reg();
        while (r == a || r == b) begin
            r = rand_reg();
        end
        return r;
    endfunction

    task automatic pick_regs();
        d = rand_reg();
        s = rand_reg_except(d, d);
        x = rand_reg_except(d, s);
        y = rand_reg_except(d, s);
        while (y == x) begin
            y = rand_reg_except(d, s);
        end
    endtask

    task automatic add_row(input logic [31:0] prod, input int gap, input logic [31:0] cons,
                           input int exp_stalls, input string label);
        row_t r;
        r.prod       = prod;
        r.gap        = gap;
        r.cons       = cons;
        r.exp_stalls = exp_stalls;
        rows.push_back(r);
        labels.push_back(label);
    endtask

    // expected count is max(0, tnew - 1 - gap - tuse) and MD_CYCLES + 1 for mult/div rows
    task automatic build_rows();
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, r_word(FN_ADDU, d, y, x), 1, "lw>alu_rs");
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, r_word(FN_ADDU, y, d, x), 1, "lw>alu_rt");
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, i_word(OP_SW, y, d, 16'h0008), 0, "lw>sw_rt");
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, i_word(OP_BEQ, d, y, 16'h0004), 2, "lw>beq");
        pick_regs();
        add_row(r_word(FN_ADDU, s, y, d), 0, i_word(OP_BNE, d, y, 16'h0004), 1, "alu>bne_g0");
        pick_regs();
        add_row(r_word(FN_ADDU, s, y, d), 1, i_word(OP_BEQ, y, d, 16'h0004), 0, "alu>beq_g1");
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 1, i_word(OP_BEQ, d, y, 16'h0004), 1, "lw>beq_g1");
        pick_regs();
        add_row(i_word(OP_ADDIU, s, d, 16'h0001), 0, r_word(FN_ADDU, d, y, x), 0, "alu>alu");
        // operands that are never read
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, i_word(OP_LUI, d, x, 16'h1234), 0, "lw>lui");
        pick_regs();
        add_row(i_word(OP_LW, s, d, 16'h0010), 0, r_word(FN_SLL, d, y, x), 0, "lw>sll");
        pick_regs();
        add_row({OP_JAL, 26'h0000040}, 0, r_word(FN_ADDU, d, y, x), 0, "jal>alu");
        // producers that write nothing
        pick_regs();
        add_row(r_word(FN_ADDU, s, y, 5'd0), 0, i_word(OP_BNE, 5'd0, 5'd0, 16'h0004), 0,
                "alu0>bne");
        pick_regs();
        add_row(i_word(OP_LW, s, 5'd0, 16'h0010), 0, i_word(OP_BEQ, 5'd0, 5'd0, 16'h0004), 0,
                "lw0>beq");
        pick_regs();
        add_row(i_word(OP_SW, s, d, 16'h0008), 0, i_word(OP_BEQ, d, s, 16'h0004), 0, "sw>beq");
        pick_regs();
        add_row(i_word(OP_BEQ, d, s, 16'h0004), 0, i_word(OP_BNE, d, s, 16'h0004), 0, "beq>bne");
        // mult/div unit
        pick_regs();
        add_row(r_word(FN_MULT, s, y, 5'd0), 0, r_word(FN_MFLO, 5'd0, 5'd0, x), MD_CYCLES + 1,
                "mult>mflo");
        pick_regs();
        add_row(r_word(FN_DIV, s, y, 5'd0), 0, r_word(FN_MFHI, 5'd0, 5'd0, x), MD_CYCLES + 1,
                "div>mfhi");
        pick_regs();
        add_row(r_word(FN_MULT, s, y, 5'd0), 0, r_word(FN_ADDU, s, y, x), 0, "mult>alu");
        cycle_limit = RESET_CYCLES + MARGIN;
        foreach (rows[i]) begin
            cycle_limit += rows[i].gap + rows[i].exp_stalls + DRAIN + 4;
        end
    endtask

    // producer, gap NOPs, consumer held through the stall, then drain
    task automatic apply_row(input row_t r, output int stalls);
        stalls = 0;
        @(posedge clk);
        #DRIVE_DELAY instr_id = r.prod;
        repeat (r.gap) begin
            @(posedge clk);
            #DRIVE_DELAY instr_id = '0;
        end
        @(posedge clk);
        #DRIVE_DELAY instr_id = r.cons;
        @(negedge clk);
        while (stall_id) begin
            stalls++;
            @(negedge clk);
        end
        repeat (DRAIN) begin
            @(posedge clk);
            #DRIVE_DELAY instr_id = '0;
        end
    endtask

    // the three stall controls move together
    always @(negedge clk) begin
        if (arst_n) begin
            check_equal("stall_id", 32'(stall_id), 32'(stall_pc));
            check_equal("clr_ex", 32'(clr_ex), 32'(stall_pc));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, consumer never released", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int stalls;
        int errors_before;
        clk      = 1'b0;
        arst_n   = 1'b0;
        instr_id = '0;
        build_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        @(negedge clk);
        check_equal("stall_pc", 32'(stall_pc), 32'h0);  // first cycle out of reset
        check_equal("stall_id", 32'(stall_id), 32'h0);
        check_equal("clr_ex", 32'(clr_ex), 32'h0);
        foreach (rows[i]) begin
            errors_before = error_count;
            apply_row(rows[i], stalls);
            check_equal("stall_cycles", stalls, rows[i].exp_stalls);
            if (error_count == errors_before) begin
                pass_count++;
            end
            $display("test %0d %s: %0d stall cycles, expected %0d, %s", i, labels[i], stalls,
                     rows[i].exp_stalls, (error_count == errors_before) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d passed, %0d errors", rows.size(), pass_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/isa_pkg.sv
logic/hazard_pkg.sv
logic/instr_class.sv
logic/tuse_tnew_decode.sv
logic/hazard_unit.sv
logic/stage_tracker.sv
logic/md_busy_timer.sv
logic/hazard_ctrl_top.sv
dv/hazard_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the stall-control testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module hazard_tb \
    -Mdir "$BUILD_DIR" -o hazard_tb_sim

"./$BUILD_DIR/hazard_tb_sim" | tee "$LOG"

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
